//--- src/pifPkg.sv
package pifPkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int wbAddrW  = 8;
    localparam int wbDataW  = 8;
    localparam int regAddrW = 4;
    localparam int subAddrW = 7;
    // payload of a received byte, upper bits are the tag
    localparam int dataW    = 6;

    // CMDR values, clock stretch off during init
    localparam logic [wbDataW-1:0] cmdClkStretchOff = 8'h04;
    localparam logic [wbDataW-1:0] cmdClkStretchOn  = 8'h00;

    // tag field of a received byte
    localparam logic [wbDataW-dataW-1:0] tagAddr = 2'b01;
    localparam logic [wbDataW-dataW-1:0] tagData = 2'b10;

    // status register bits
    localparam int srTip   = 7;
    localparam int srBusy  = 6;
    localparam int srRarc  = 5;
    localparam int srSrw   = 4;
    localparam int srTrrdy = 2;
    localparam int srTroe  = 1;

    // ----------------------------------------
    // enums
    // ----------------------------------------
    // primary I2C registers of the hard block
    typedef enum logic [7:0] {
        RegCmdr = 8'h41,
        RegTxdr = 8'h44,
        RegSr   = 8'h45,
        RegRxdr = 8'h47
    } efbReg_e;

    typedef enum logic [3:0] {
        StStart, StInit1, StInit2, StInit3, StInit4,
        StIdle, StWaitTr, StIn0, StOut0, StOut1, StWr, StRd
    } pollState_e;

    typedef enum logic [1:0] {
        TagNone, TagAddr, TagData
    } rxTag_e;

    // ----------------------------------------
    // structs
    // ----------------------------------------
    typedef struct packed {
        logic               valid;
        logic               we;
        efbReg_e            addr;
        logic [wbDataW-1:0] wdata;
    } busReq_t;

    typedef struct packed {
        logic               done;
        logic [wbDataW-1:0] rdata;
    } busRsp_t;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [wbAddrW-1:0] adr;
        logic [wbDataW-1:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic             valid;
        rxTag_e           tag;
        logic [dataW-1:0] payload;
    } rxByte_t;

    typedef struct packed {
        logic                wr;
        logic [regAddrW-1:0] addr;
        logic                rdFinished;
        logic [subAddrW-1:0] rdSubAddr;
        logic [dataW-1:0]    data;
    } pifPort_t;

endpackage

//--- src/wbMaster.sv
`timescale 1ns/1ps

module wbMaster (
    input  logic                         xclk,
    input  logic                         rst,
    input  pifPkg::busReq_t              req_i,
    input  logic                         wbAck_i,
    input  logic [pifPkg::wbDataW-1:0]   wbDat_i,
    output pifPkg::busRsp_t              rsp_o,
    output pifPkg::wbReq_t               wb_o
);

    pifPkg::wbReq_t  wbQ;
    pifPkg::busRsp_t rspQ;

    // ----------------------------------------
    // bus cycle
    // ----------------------------------------
    always_ff @(posedge xclk or posedge rst) begin
        if (rst) begin
            wbQ <= '0;
        end else if (wbQ.cyc) begin
            // hold everything until the slave acks
            if (wbAck_i) begin
                wbQ.cyc <= 1'b0;
                wbQ.stb <= 1'b0;
                wbQ.we  <= 1'b0;
            end
        end else if (req_i.valid) begin
            wbQ.cyc <= 1'b1;
            wbQ.stb <= 1'b1;
            wbQ.we  <= req_i.we;
            wbQ.adr <= req_i.addr;
            wbQ.dat <= req_i.wdata;
        end
    end

    // ----------------------------------------
    // response
    // ----------------------------------------
    always_ff @(posedge xclk or posedge rst) begin
        if (rst) begin
            rspQ <= '0;
        end else begin
            rspQ.done <= wbQ.cyc & wbAck_i;
            // read data only meaningful with done
            if (wbQ.cyc && wbAck_i) begin
                rspQ.rdata <= wbDat_i;
            end
        end
    end

    assign wb_o  = wbQ;
    assign rsp_o = rspQ;

endmodule

//--- src/i2cPollFsm.sv
`timescale 1ns/1ps

module i2cPollFsm (
    input  logic                         xclk,
    input  logic                         rst,
    input  pifPkg::busRsp_t              rsp_i,
    input  logic [pifPkg::wbDataW-1:0]   txData_i,
    output pifPkg::busReq_t              req_o,
    output pifPkg::rxByte_t              rx_o,
    output logic                         txDone_o
);

    pifPkg::pollState_e state;
    pifPkg::pollState_e rwReturn;
    pifPkg::busReq_t    reqQ;
    pifPkg::rxByte_t    rxQ;
    logic               txDoneQ;

    // flags from the latest SR read
    logic busy;
    logic txReady;
    logic rxReady;
    logic lastTxNak;

    // decode of the status byte on the bus response
    logic srBusyNow;
    logic srTxReady;
    logic srRxReady;
    logic srTxNak;

    assign srBusyNow = rsp_i.rdata[pifPkg::srBusy];
    assign srTxReady = srBusyNow & rsp_i.rdata[pifPkg::srTrrdy]
                     & rsp_i.rdata[pifPkg::srSrw] & ~rsp_i.rdata[pifPkg::srTip];
    assign srRxReady = srBusyNow & rsp_i.rdata[pifPkg::srTrrdy] & ~rsp_i.rdata[pifPkg::srSrw];
    assign srTxNak   = srBusyNow & rsp_i.rdata[pifPkg::srRarc]
                     & rsp_i.rdata[pifPkg::srSrw] & rsp_i.rdata[pifPkg::srTroe];

    function automatic pifPkg::busReq_t mkReq(input logic we, input pifPkg::efbReg_e addr,
                                              input logic [pifPkg::wbDataW-1:0] wdata);
        pifPkg::busReq_t r;
        r.valid = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic pifPkg::rxTag_e decodeTag(
        input logic [pifPkg::wbDataW-pifPkg::dataW-1:0] tag);
        case (tag)
            pifPkg::tagAddr: return pifPkg::TagAddr;
            pifPkg::tagData: return pifPkg::TagData;
            default:         return pifPkg::TagNone;
        endcase
    endfunction

    // ----------------------------------------
    // sequencer
    // ----------------------------------------
    always_ff @(posedge xclk or posedge rst) begin
        if (rst) begin
            state     <= pifPkg::StStart;
            rwReturn  <= pifPkg::StStart;
            reqQ      <= '0;
            rxQ       <= '0;
            txDoneQ   <= 1'b0;
            busy      <= 1'b0;
            txReady   <= 1'b0;
            rxReady   <= 1'b0;
            lastTxNak <= 1'b0;
        end else begin
            reqQ.valid <= 1'b0;
            rxQ.valid  <= 1'b0;
            txDoneQ    <= 1'b0;
            case (state)
                // init, stretch off then drain RXDR
                pifPkg::StStart: begin
                    reqQ     <= mkReq(1'b1, pifPkg::RegCmdr, pifPkg::cmdClkStretchOff);
                    rwReturn <= pifPkg::StInit1;
                    state    <= pifPkg::StWr;
                end
                pifPkg::StInit1: begin
                    reqQ     <= mkReq(1'b0, pifPkg::RegSr, '0);
                    rwReturn <= pifPkg::StInit2;
                    state    <= pifPkg::StRd;
                end
                pifPkg::StInit2: begin
                    // keep polling SR while the bus is busy
                    reqQ  <= mkReq(1'b0, busy ? pifPkg::RegSr : pifPkg::RegRxdr, '0);
                    state <= pifPkg::StRd;
                    if (!busy) begin
                        rwReturn <= pifPkg::StInit3;
                    end
                end
                pifPkg::StInit3: begin
                    reqQ     <= mkReq(1'b0, pifPkg::RegRxdr, '0);
                    rwReturn <= pifPkg::StInit4;
                    state    <= pifPkg::StRd;
                end
                pifPkg::StInit4: begin
                    reqQ     <= mkReq(1'b1, pifPkg::RegCmdr, pifPkg::cmdClkStretchOn);
                    rwReturn <= pifPkg::StIdle;
                    state    <= pifPkg::StWr;
                end
                // wait for I2C activity
                pifPkg::StIdle: begin
                    reqQ     <= mkReq(1'b0, pifPkg::RegSr, '0);
                    rwReturn <= busy ? pifPkg::StWaitTr : pifPkg::StIdle;
                    state    <= pifPkg::StRd;
                end
                pifPkg::StWaitTr: begin
                    if (lastTxNak || (!txReady && !rxReady && !busy)) begin
                        state <= pifPkg::StStart;
                    end else if (txReady) begin
                        reqQ     <= mkReq(1'b1, pifPkg::RegTxdr, txData_i);
                        rwReturn <= pifPkg::StOut0;
                        state    <= pifPkg::StWr;
                    end else if (rxReady) begin
                        reqQ     <= mkReq(1'b0, pifPkg::RegRxdr, '0);
                        rwReturn <= pifPkg::StIn0;
                        state    <= pifPkg::StRd;
                    end else begin
                        reqQ     <= mkReq(1'b0, pifPkg::RegSr, '0);
                        rwReturn <= pifPkg::StWaitTr;
                        state    <= pifPkg::StRd;
                    end
                end
                pifPkg::StIn0:  state <= pifPkg::StIdle;
                pifPkg::StOut0: state <= pifPkg::StOut1;
                pifPkg::StOut1: state <= pifPkg::StIdle;
                // bus transfers in flight
                pifPkg::StWr: begin
                    if (rsp_i.done) begin
                        state   <= rwReturn;
                        txDoneQ <= (rwReturn == pifPkg::StOut0);
                    end
                end
                pifPkg::StRd: begin
                    if (rsp_i.done) begin
                        state <= rwReturn;
                        if (reqQ.addr == pifPkg::RegSr) begin
                            busy      <= srBusyNow;
                            txReady   <= srTxReady;
                            rxReady   <= srRxReady;
                            lastTxNak <= srTxNak;
                        end else if (rwReturn == pifPkg::StIn0) begin
                            // init reads of RXDR are discarded
                            rxQ.valid   <= 1'b1;
                            rxQ.tag     <= decodeTag(
                                rsp_i.rdata[pifPkg::wbDataW-1:pifPkg::dataW]);
                            rxQ.payload <= rsp_i.rdata[pifPkg::dataW-1:0];
                        end
                    end
                end
                default: state <= pifPkg::StStart;
            endcase
        end
    end

    assign req_o    = reqQ;
    assign rx_o     = rxQ;
    assign txDone_o = txDoneQ;

endmodule

//--- src/pifRegPort.sv
`timescale 1ns/1ps

module pifRegPort (
    input  logic               xclk,
    input  logic               rst,
    input  pifPkg::rxByte_t    rx_i,
    input  logic               txDone_i,
    output pifPkg::pifPort_t   pif_o
);

    logic [pifPkg::regAddrW-1:0] regAddr;
    logic [pifPkg::subAddrW-1:0] rdSubAddr;
    logic [pifPkg::dataW-1:0]    wrData;
    logic                        wrQ;
    logic                        rdFinQ;

    logic addrHit;
    logic dataHit;

    assign addrHit = rx_i.valid && (rx_i.tag == pifPkg::TagAddr);
    assign dataHit = rx_i.valid && (rx_i.tag == pifPkg::TagData);

    // ----------------------------------------
    // register address and read sub-address
    // ----------------------------------------
    always_ff @(posedge xclk or posedge rst) begin
        if (rst) begin
            regAddr   <= '0;
            rdSubAddr <= '0;
        end else if (addrHit) begin
            // new address restarts the read burst
            regAddr   <= rx_i.payload[pifPkg::regAddrW-1:0];
            rdSubAddr <= '0;
        end else if (txDone_i) begin
            // wraps at full width
            rdSubAddr <= rdSubAddr + 1'b1;
        end
    end

    // ----------------------------------------
    // write data and strobes
    // ----------------------------------------
    always_ff @(posedge xclk or posedge rst) begin
        if (rst) begin
            wrData <= '0;
            wrQ    <= 1'b0;
            rdFinQ <= 1'b0;
        end else begin
            wrQ    <= dataHit;
            rdFinQ <= txDone_i;
            if (dataHit) begin
                wrData <= rx_i.payload;
            end
        end
    end

    assign pif_o = '{wr:         wrQ,
                     addr:       regAddr,
                     rdFinished: rdFinQ,
                     rdSubAddr:  rdSubAddr,
                     data:       wrData};

endmodule

//--- src/pifBridge.sv
`timescale 1ns/1ps

module pifBridge (
    input  logic                         xclk,
    input  logic                         rst,
    input  logic                         wbAck_i,
    input  logic [pifPkg::wbDataW-1:0]   wbDat_i,
    input  logic [pifPkg::wbDataW-1:0]   txData_i,
    output pifPkg::wbReq_t               wb_o,
    output pifPkg::pifPort_t             pif_o
);

    pifPkg::busReq_t busReq;
    pifPkg::busRsp_t busRsp;
    pifPkg::rxByte_t rxByte;
    logic            txDone;

    // ----------------------------------------
    // Wishbone side
    // ----------------------------------------
    wbMaster wbMaster_inst (
        .xclk    (xclk),
        .rst     (rst),
        .req_i   (busReq),
        .wbAck_i (wbAck_i),
        .wbDat_i (wbDat_i),
        .rsp_o   (busRsp),
        .wb_o    (wb_o)
    );

    // status polling and byte routing
    i2cPollFsm i2cPollFsm_inst (
        .xclk     (xclk),
        .rst      (rst),
        .rsp_i    (busRsp),
        .txData_i (txData_i),
        .req_o    (busReq),
        .rx_o     (rxByte),
        .txDone_o (txDone)
    );

    // ----------------------------------------
    // register port side
    // ----------------------------------------
    pifRegPort pifRegPort_inst (
        .xclk     (xclk),
        .rst      (rst),
        .rx_i     (rxByte),
        .txDone_i (txDone),
        .pif_o    (pif_o)
    );

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic xclk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        xclk_o = 1'b0;
        forever #5 xclk_o = ~xclk_o;
    end

    // reset held for three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge xclk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- dv/efbModel.sv
`timescale 1ns/1ps

module efbModel (
    input  logic           xclk,
    input  logic           rst,
    input  pifPkg::wbReq_t wb_i,
    output logic           wbAck_o,
    output logic [7:0]     wbDat_o
);

    // loaded from the testbench top
    logic [7:0]      rxQueue[$];
    int              txPending;
    int              nakReads;
    bit              maxDelay;

    // every write in bus order
    pifPkg::efbReg_e writeReg[$];
    logic [7:0]      writeDat[$];

    logic [15:0]     lfsr;
    int              waitLeft;
    bit              active;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] stepLfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // 0 to 3 wait cycles, one step per bit
    task automatic drawDelay(output int d);
        d = 0;
        repeat (2) begin
            lfsr = stepLfsr(lfsr);
            d = (d << 1) | lfsr[0];
        end
    endtask

    function automatic logic [7:0] statusByte();
        logic [7:0] sr;
        sr = '0;
        if (rxQueue.size() > 0) begin
            sr[pifPkg::srBusy]  = 1'b1;
            sr[pifPkg::srTrrdy] = 1'b1;
        end else if (txPending > 0) begin
            sr[pifPkg::srBusy]  = 1'b1;
            sr[pifPkg::srTrrdy] = 1'b1;
            sr[pifPkg::srSrw]   = 1'b1;
        end else if (nakReads > 0) begin
            sr[pifPkg::srBusy]  = 1'b1;
            sr[pifPkg::srRarc]  = 1'b1;
            sr[pifPkg::srSrw]   = 1'b1;
            sr[pifPkg::srTroe]  = 1'b1;
        end
        return sr;
    endfunction

    initial begin
        txPending = 0;
        nakReads  = 0;
        maxDelay  = 1'b0;
        lfsr      = 16'd35870;
        wbAck_o   = 1'b0;
        wbDat_o   = '0;
    end

    // ----------------------------------------
    // Wishbone slave
    // ----------------------------------------
    always @(posedge xclk or posedge rst) begin
        if (rst) begin
            wbAck_o <= 1'b0;
            wbDat_o <= '0;
            active  = 1'b0;
            waitLeft = 0;
        end else begin
            wbAck_o <= 1'b0;
            if (wb_i.cyc && wb_i.stb && !wbAck_o) begin
                if (!active) begin
                    active = 1'b1;
                    if (maxDelay) begin
                        waitLeft = 3;
                    end else begin
                        drawDelay(waitLeft);
                    end
                end
                if (waitLeft > 0) begin
                    waitLeft--;
                end else begin
                    active = 1'b0;
                    wbAck_o <= 1'b1;
                    if (wb_i.we) begin
                        writeReg.push_back(pifPkg::efbReg_e'(wb_i.adr));
                        writeDat.push_back(wb_i.dat);
                        if (wb_i.adr == pifPkg::RegTxdr && txPending > 0) begin
                            txPending--;
                        end
                    end else if (wb_i.adr == pifPkg::RegSr) begin
                        wbDat_o <= statusByte();
                        // NAK is shown for a set number of SR reads
                        if (rxQueue.size() == 0 && txPending == 0 && nakReads > 0) begin
                            nakReads--;
                        end
                    end else if (wb_i.adr == pifPkg::RegRxdr && rxQueue.size() > 0) begin
                        wbDat_o <= rxQueue.pop_front();
                    end else begin
                        wbDat_o <= '0;
                    end
                end
            end
        end
    end

endmodule

//--- dv/pifBridge_chk.sv
`timescale 1ns/1ps

module pifBridge_chk (
    input logic             xclk,
    input logic             rst,
    input pifPkg::wbReq_t   wb_i,
    input logic             wbAck_i,
    input pifPkg::pifPort_t pif_i
);

    // assertion failures so far
    int failCount = 0;

    stbHasCyc: assert property (@(posedge xclk) disable iff (rst) wb_i.stb |-> wb_i.cyc) else begin
        failCount++;
        $error("stb high without cyc");
    end

    // request fields frozen until the slave acks
    reqHeld: assert property (@(posedge xclk) disable iff (rst)
        (wb_i.stb && !wbAck_i) |=> ($stable(wb_i.adr) && $stable(wb_i.dat) && $stable(wb_i.we)))
    else begin
        failCount++;
        $error("Wishbone request changed before ack");
    end

    wrSingle: assert property (@(posedge xclk) disable iff (rst) pif_i.wr |=> !pif_i.wr) else begin
        failCount++;
        $error("wr high two cycles running");
    end

    rdFinSingle: assert property (@(posedge xclk) disable iff (rst)
        pif_i.rdFinished |=> !pif_i.rdFinished)
    else begin
        failCount++;
        $error("rdFinished high two cycles running");
    end

    cycLowAfterReset: assert property (@(posedge xclk) $fell(rst) |-> !wb_i.cyc) else begin
        failCount++;
        $error("cyc high right after reset");
    end

endmodule

//--- dv/tbPifBridge.sv
`timescale 1ns/1ps

module tbPifBridge;

    // bytes pushed through the bridge over all tests with the NAK as one
    localparam int queuedBytes    = 2 + 4 + 5 + 1 + 2 + 5;
    localparam int watchdogCycles = queuedBytes * 200 + 2000;

    logic             xclk;
    logic             rst;
    logic             wbAck;
    logic [7:0]       wbDat;
    logic [7:0]       txData;
    pifPkg::wbReq_t   wb;
    pifPkg::pifPort_t pif;

    logic [pifPkg::dataW-1:0]    wrLog[$];
    logic [pifPkg::subAddrW-1:0] subLog[$];
    logic [15:0]                 lfsr = 16'd35870;
    int                          errorCount;

    tbClock tbClock_inst (
        .xclk_o (xclk),
        .rst_o  (rst)
    );

    efbModel efbModel_inst (
        .xclk    (xclk),
        .rst     (rst),
        .wb_i    (wb),
        .wbAck_o (wbAck),
        .wbDat_o (wbDat)
    );

    pifBridge pifBridge_inst (
        .xclk     (xclk),
        .rst      (rst),
        .wbAck_i  (wbAck),
        .wbDat_i  (wbDat),
        .txData_i (txData),
        .wb_o     (wb),
        .pif_o    (pif)
    );

    bind pifBridge pifBridge_chk pifBridge_chk_inst (
        .xclk    (xclk),
        .rst     (rst),
        .wb_i    (wb_o),
        .wbAck_i (wbAck_i),
        .pif_i   (pif_o)
    );

    // ----------------------------------------
    // monitor and compare tasks
    // ----------------------------------------
    always @(posedge xclk) begin
        if (!rst && pif.wr) wrLog.push_back(pif.data);
        if (!rst && pif.rdFinished) subLog.push_back(pif.rdSubAddr);
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkReg(input string name, input pifPkg::efbReg_e got, exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkAddr(input string name, input logic [pifPkg::regAddrW-1:0] got, exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkData(input string name, input logic [pifPkg::dataW-1:0] got, exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkSub(input string name, input logic [pifPkg::subAddrW-1:0] got, exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkCount(input string name, input int got, exp);
        if (got != exp) reportMismatch(name, got, exp);
    endtask

    function automatic logic [pifPkg::dataW-1:0] randPayload();
        logic [pifPkg::dataW-1:0] v;
        v = '0;
        repeat (pifPkg::dataW) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[pifPkg::dataW-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // wait for the re-init writes CMDR 0x04 then 0x00
    task automatic waitRestart(input int base);
        while (efbModel_inst.writeReg.size() < base + 2) @(posedge xclk);
        checkReg("CMDR write address", efbModel_inst.writeReg[base], pifPkg::RegCmdr);
        checkByte("CMDR stretch off", efbModel_inst.writeDat[base], 8'h04);
        checkReg("CMDR write address", efbModel_inst.writeReg[base + 1], pifPkg::RegCmdr);
        checkByte("CMDR stretch on", efbModel_inst.writeDat[base + 1], 8'h00);
        repeat (2) @(posedge xclk);
    endtask

    task automatic sendAddr(input logic [pifPkg::dataW-1:0] pay);
        int base;
        base = efbModel_inst.writeReg.size();
        @(posedge xclk);
        efbModel_inst.rxQueue.push_back({pifPkg::tagAddr, pay});
        waitRestart(base);
        checkAddr("pif_o.addr", pif.addr, pay[pifPkg::regAddrW-1:0]);
        checkSub("pif_o.rdSubAddr", pif.rdSubAddr, '0);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic testResetInit();
        wait (rst == 1'b0);
        @(posedge xclk);
        checkAddr("pif_o.addr", pif.addr, '0);
        checkData("pif_o.data", pif.data, '0);
        checkSub("pif_o.rdSubAddr", pif.rdSubAddr, '0);
        checkByte("pif_o strobes", {6'b0, pif.wr, pif.rdFinished}, 8'h00);
        waitRestart(0);
    endtask

    task automatic testAddrData(input logic [pifPkg::dataW-1:0] addrPay, dataPay);
        int base;
        base = efbModel_inst.writeReg.size();
        wrLog.delete();
        @(posedge xclk);
        efbModel_inst.rxQueue.push_back({pifPkg::tagAddr, addrPay});
        efbModel_inst.rxQueue.push_back({pifPkg::tagData, dataPay});
        waitRestart(base);
        checkAddr("pif_o.addr", pif.addr, addrPay[pifPkg::regAddrW-1:0]);
        checkCount("wr pulses", wrLog.size(), 1);
        checkData("pif_o.data", wrLog[0], dataPay);
        checkSub("pif_o.rdSubAddr", pif.rdSubAddr, '0);
    endtask

    task automatic testDataBurst(input int n);
        logic [pifPkg::dataW-1:0] expQ[$];
        int base;
        base = efbModel_inst.writeReg.size();
        wrLog.delete();
        @(posedge xclk);
        repeat (n) begin
            expQ.push_back(randPayload());
            efbModel_inst.rxQueue.push_back({pifPkg::tagData, expQ[$]});
        end
        waitRestart(base);
        checkCount("wr pulses", wrLog.size(), n);
        foreach (expQ[i]) checkData("pif_o.data", wrLog[i], expQ[i]);
    endtask

    task automatic testMasterRead(input int n, input logic [7:0] txVal);
        int base;
        @(posedge xclk);
        txData <= txVal;
        sendAddr(6'h07);
        base = efbModel_inst.writeReg.size();
        subLog.delete();
        efbModel_inst.txPending = n;
        // init runs again once the last byte has left the bus
        waitRestart(base + n);
        for (int i = 0; i < n; i++) begin
            checkReg("TXDR write address", efbModel_inst.writeReg[base + i], pifPkg::RegTxdr);
            checkByte("TXDR data", efbModel_inst.writeDat[base + i], txVal);
        end
        checkCount("rdFinished pulses", subLog.size(), n);
        foreach (subLog[i]) checkSub("pif_o.rdSubAddr", subLog[i], pifPkg::subAddrW'(i + 1));
        sendAddr(6'h03);
    endtask

    task automatic testNak();
        int base;
        base = efbModel_inst.writeReg.size();
        wrLog.delete();
        subLog.delete();
        @(posedge xclk);
        efbModel_inst.nakReads = 4;
        // restart has to begin while the NAK status is still shown
        while (efbModel_inst.writeReg.size() < base + 1) @(posedge xclk);
        if (efbModel_inst.nakReads == 0) begin
            stopWithError("bridge did not restart on the NAK status");
        end
        waitRestart(base);
        checkCount("strobes after NAK", wrLog.size() + subLog.size(), 0);
    endtask

    initial begin
        errorCount = 0;
        txData <= 8'h00;
        testResetInit();
        testAddrData(6'h2B, 6'h15);
        testDataBurst(4);
        testMasterRead(3, 8'hA5);
        testNak();
        // same sequences with every ack held for the longest delay
        efbModel_inst.maxDelay = 1'b1;
        testAddrData(6'h1E, 6'h2A);
        testMasterRead(3, 8'h5C);
        errorCount = pifBridge_inst.pifBridge_chk_inst.failCount;
        if (errorCount == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("bus or strobe assertions failed %0d times", errorCount);
            $display("tests failed");
            $fatal(1);
        end
    end

    // first failure of the bound checker ends the run
    initial begin
        wait (pifBridge_inst.pifBridge_chk_inst.failCount != 0);
        $display("a bus or strobe assertion failed");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        repeat (watchdogCycles) @(posedge xclk);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $fatal(1);
    end

endmodule

//--- filelist.f
src/pifPkg.sv
src/wbMaster.sv
src/i2cPollFsm.sv
src/pifRegPort.sv
src/pifBridge.sv
dv/tbClock.sv
dv/efbModel.sv
dv/pifBridge_chk.sv
dv/tbPifBridge.sv

//--- Bender.yml
package:
  name: pif_bridge

sources:
  # design
  - files:
      - src/pifPkg.sv
      - src/wbMaster.sv
      - src/i2cPollFsm.sv
      - src/pifRegPort.sv
      - src/pifBridge.sv
  # testbench
  - target: test
    files:
      - dv/tbClock.sv
      - dv/efbModel.sv
      - dv/pifBridge_chk.sv
      - dv/tbPifBridge.sv
